// ==== src.f ====
+incdir+include
source/disp_pkg.sv
source/pix_pkg.sv
source/video_timing.sv
source/depth_writer.sv
source/buffer_clear.sv
source/buffer_arbiter.sv
source/frame_store.sv
source/scanout.sv
source/display_top.sv
testbench/display_tb.sv

// ==== include/display_tb_model.svh ====
`ifndef DISPLAY_TB_MODEL_SVH
`define DISPLAY_TB_MODEL_SVH

// Two colour buffers indexed by the back select, one shared depth buffer
logic [pix_pkg::COLOR_WIDTH-1:0] model_fb [2][disp_pkg::FB_DEPTH];
logic [pix_pkg::DEPTH_WIDTH-1:0] model_db [disp_pkg::FB_DEPTH];
logic                            model_known [2];
logic                            model_back;

task automatic reset_model();
    int a;
    model_back     = 1'b0;
    model_known[0] = 1'b0;
    model_known[1] = 1'b0;
    for (a = 0; a < disp_pkg::FB_DEPTH; a++) begin
        model_fb[0][a] = 'x;
        model_fb[1][a] = 'x;
        model_db[a]    = 'x;
    end
endtask

// Strictly closer wins, so a tie keeps the earlier pixel
task automatic apply_pixel(input logic [disp_pkg::ADDR_WIDTH-1:0] addr,
                           input logic [pix_pkg::COLOR_WIDTH-1:0] color,
                           input logic [pix_pkg::DEPTH_WIDTH-1:0] depth);
    if (depth < model_db[addr]) begin
        model_fb[model_back][addr] = color;
        model_db[addr]             = depth;
    end
endtask

task automatic clear_back_buffer();
    int a;
    for (a = 0; a < disp_pkg::FB_DEPTH; a++) begin
        model_fb[model_back][a] = pix_pkg::FB_CLEAR_VALUE;
        model_db[a]             = pix_pkg::DB_CLEAR_VALUE;
    end
    model_known[model_back] = 1'b1;
endtask

task automatic toggle_select();
    model_back = !model_back;
endtask

function automatic logic front_is_known();
    return model_known[!model_back];
endfunction

function automatic logic de_at(input int h, input int v);
    return (h < disp_pkg::H_ACTIVE) && (v < disp_pkg::V_ACTIVE);
endfunction

// Syncs are low inside their windows
function automatic logic hsync_at(input int h);
    return !(h >= disp_pkg::H_SYNC_START && h < disp_pkg::H_SYNC_END);
endfunction

function automatic logic vsync_at(input int v);
    return !(v >= disp_pkg::V_SYNC_START && v < disp_pkg::V_SYNC_END);
endfunction

function automatic logic [pix_pkg::RGB_WIDTH-1:0] pixel_rgb(input int h, input int v);
    int addr;
    addr = (v / disp_pkg::SCALE) * disp_pkg::FB_WIDTH + h / disp_pkg::SCALE;
    return pix_pkg::PALETTE[model_fb[!model_back][addr]];
endfunction

`endif

// ==== testbench/display_tb.sv ====
`timescale 1ns/1ns

module display_tb;

    localparam int CLK_PERIOD     = 10;
    localparam int FRAME_CYCLES   = disp_pkg::H_TOTAL * disp_pkg::V_TOTAL;
    localparam int TEST_FRAMES    = 16;
    localparam int CLEAR_ALLOW_NS = 3 * (disp_pkg::FB_DEPTH + 4) * CLK_PERIOD;
    localparam int RENDER_CYCLES  = 400;
    localparam int IGNORED_CYCLES = 12;
    localparam int HOLD_FRAMES    = 2;
    localparam int READY_LIMIT    = FRAME_CYCLES + disp_pkg::FB_DEPTH + 8;

    logic                            clk;
    logic                            rstn;
    logic                            i_pixel_valid;
    logic [disp_pkg::ADDR_WIDTH-1:0] i_pixel_addr;
    logic [pix_pkg::COLOR_WIDTH-1:0] i_pixel_color;
    logic [pix_pkg::DEPTH_WIDTH-1:0] i_pixel_depth;
    logic                            i_frame_clear;
    logic                            i_frame_done;
    logic                            o_render_ready;
    logic                            o_hsync;
    logic                            o_vsync;
    logic                            o_de;
    logic [pix_pkg::CHAN_WIDTH-1:0]  o_red;
    logic [pix_pkg::CHAN_WIDTH-1:0]  o_green;
    logic [pix_pkg::CHAN_WIDTH-1:0]  o_blue;

    logic [31:0]                    rng_state;
    logic                           swap_wait;
    int                             rgb_errors = 0;
    int                             level_errors = 0;
    int                             ready_errors = 0;
    int                             other_errors = 0;
    int                             scan_h;
    int                             scan_v;
    int                             out_cycle;
    logic                           locked;
    logic [pix_pkg::RGB_WIDTH-1:0]  rgb;

    `include "display_tb_model.svh"

    display_top DUT (
        .clk            (clk),
        .rstn           (rstn),
        .i_pixel_valid  (i_pixel_valid),
        .i_pixel_addr   (i_pixel_addr),
        .i_pixel_color  (i_pixel_color),
        .i_pixel_depth  (i_pixel_depth),
        .i_frame_clear  (i_frame_clear),
        .i_frame_done   (i_frame_done),
        .o_render_ready (o_render_ready),
        .o_hsync        (o_hsync),
        .o_vsync        (o_vsync),
        .o_de           (o_de),
        .o_red          (o_red),
        .o_green        (o_green),
        .o_blue         (o_blue)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_random(output logic [31:0] r);
        rng_state = xorshift(rng_state);
        r = rng_state;
    endtask

    task automatic check_rgb(input logic [pix_pkg::RGB_WIDTH-1:0] got,
                             input logic [pix_pkg::RGB_WIDTH-1:0] exp, input string what);
        if (got !== exp) begin
            rgb_errors++;
            $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic verify_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            level_errors++;
            $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic expect_ready(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            ready_errors++;
            $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // Swap lands on the rise of ready after a frame done
    task automatic track_swap();
        if (swap_wait && o_render_ready) begin
            toggle_select();
            swap_wait = 1'b0;
        end
    endtask

    task automatic wait_ready_rise(output int low_cycles);
        low_cycles = 0;
        while (!o_render_ready && low_cycles < READY_LIMIT) begin
            low_cycles++;
            @(negedge clk);
        end
        if (!o_render_ready) begin
            other_errors++;
            $display("o_render_ready did not rise within %0d cycles", READY_LIMIT);
        end
        track_swap();
    endtask

    task automatic render_pixels(input int cycles);
        logic [31:0]                     ctl;
        logic [31:0]                     val;
        logic [disp_pkg::ADDR_WIDTH-1:0] addr;
        int                              i;
        addr = '0;
        for (i = 0; i < cycles; i++) begin
            next_random(ctl);
            next_random(val);
            // Keep the last address now and then for same-address hits
            if (ctl[1:0] != 2'd0) begin
                addr = disp_pkg::ADDR_WIDTH'(ctl[31:8] % disp_pkg::FB_DEPTH);
            end
            @(posedge clk);
            i_pixel_valid <= (ctl[4:2] != 3'd0);
            i_pixel_addr  <= addr;
            i_pixel_color <= val[3:0];
            if (val[7:4] == 4'hf) begin
                i_pixel_depth <= {pix_pkg::DEPTH_WIDTH{1'b1}};
            end else begin
                i_pixel_depth <= {val[11:8], 4'h0};
            end
            @(negedge clk);
            track_swap();
            if (i_pixel_valid && o_render_ready) begin
                apply_pixel(i_pixel_addr, i_pixel_color, i_pixel_depth);
            end
        end
        @(posedge clk);
        i_pixel_valid <= 1'b0;
        @(negedge clk);
        track_swap();
    endtask

    task automatic clear_frame();
        int low_cycles;
        @(posedge clk);
        i_frame_clear <= 1'b1;
        @(negedge clk);
        expect_ready(o_render_ready, 1'b1, "o_render_ready at clear");
        clear_back_buffer();
        @(posedge clk);
        i_frame_clear <= 1'b0;
        @(negedge clk);
        expect_ready(o_render_ready, 1'b0, "o_render_ready after clear");
        wait_ready_rise(low_cycles);
        if (low_cycles < disp_pkg::FB_DEPTH || low_cycles > disp_pkg::FB_DEPTH + 3) begin
            other_errors++;
            $display("[ERROR] %0t: clear kept ready low %0d cycles", $time, low_cycles);
        end
    endtask

    // Pixels offered while ready is low must be dropped
    task automatic swap_frame();
        int low_cycles;
        @(posedge clk);
        i_frame_done <= 1'b1;
        @(negedge clk);
        expect_ready(o_render_ready, 1'b1, "o_render_ready at frame done");
        @(posedge clk);
        i_frame_done <= 1'b0;
        @(negedge clk);
        expect_ready(o_render_ready, 1'b0, "o_render_ready after frame done");
        swap_wait = 1'b1;
        render_pixels(IGNORED_CYCLES);
        wait_ready_rise(low_cycles);
    endtask

    task automatic hold_frames(input int frames);
        repeat (frames * FRAME_CYCLES) @(negedge clk);
    endtask

    // Screen position locks to the first enabled output
    always @(negedge clk) begin
        if (!rstn) begin
            locked    = 1'b0;
            out_cycle = 0;
            scan_h    = 0;
            scan_v    = 0;
        end else begin
            if (!locked) begin
                // Counters leave reset at the first active position
                verify_level(o_de, out_cycle == disp_pkg::SCAN_LATENCY, "o_de out of reset");
                locked    = o_de;
                out_cycle = out_cycle + 1;
            end else begin
                scan_h = (scan_h == disp_pkg::H_TOTAL - 1) ? 0 : scan_h + 1;
                if (scan_h == 0) begin
                    scan_v = (scan_v == disp_pkg::V_TOTAL - 1) ? 0 : scan_v + 1;
                end
            end
            if (locked) begin
                verify_level(o_de, de_at(scan_h, scan_v), "o_de");
                verify_level(o_hsync, hsync_at(scan_h), "o_hsync");
                verify_level(o_vsync, vsync_at(scan_v), "o_vsync");
            end else begin
                verify_level(o_hsync, 1'b1, "o_hsync before first line");
                verify_level(o_vsync, 1'b1, "o_vsync before first line");
            end
            rgb = {o_red, o_green, o_blue};
            if (!o_de) begin
                check_rgb(rgb, '0, "RGB in blanking");
            end else if (locked && front_is_known()) begin
                check_rgb(rgb, pixel_rgb(scan_h, scan_v),
                          $sformatf("pixel at x %0d y %0d", scan_h, scan_v));
            end
        end
    end

    initial begin
        clk           = 1'b0;
        rstn          = 1'b0;
        i_pixel_valid = 1'b0;
        i_pixel_addr  = '0;
        i_pixel_color = '0;
        i_pixel_depth = '0;
        i_frame_clear = 1'b0;
        i_frame_done  = 1'b0;
        rng_state     = 32'h73ab_e2d1;
        swap_wait     = 1'b0;
        reset_model();
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        expect_ready(o_render_ready, 1'b1, "o_render_ready after reset");
        verify_level(o_de, 1'b0, "o_de after reset");
        verify_level(o_hsync, 1'b1, "o_hsync after reset");
        verify_level(o_vsync, 1'b1, "o_vsync after reset");
        check_rgb({o_red, o_green, o_blue}, '0, "RGB after reset");

        // First image into buffer 0
        clear_frame();
        render_pixels(RENDER_CYCLES);
        swap_frame();
        hold_frames(HOLD_FRAMES);

        // Second image rendered while the first one is shown
        clear_frame();
        render_pixels(RENDER_CYCLES);
        hold_frames(HOLD_FRAMES);
        swap_frame();
        hold_frames(HOLD_FRAMES);

        // Drawn over the old image and depths without a clear
        render_pixels(RENDER_CYCLES);
        swap_frame();
        hold_frames(HOLD_FRAMES);

        $display("Errors: rgb %0d, sync %0d, ready %0d, other %0d",
                 rgb_errors, level_errors, ready_errors, other_errors);
        if (rgb_errors + level_errors + ready_errors + other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(TEST_FRAMES * FRAME_CYCLES * CLK_PERIOD + CLEAR_ALLOW_NS);
        $display("Timeout: the run did not finish in time");
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== source/display_top.sv ====
`timescale 1ns/1ns

module display_top (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            i_pixel_valid,
    input  logic [disp_pkg::ADDR_WIDTH-1:0] i_pixel_addr,
    input  logic [pix_pkg::COLOR_WIDTH-1:0] i_pixel_color,
    input  logic [pix_pkg::DEPTH_WIDTH-1:0] i_pixel_depth,
    input  logic                            i_frame_clear,
    input  logic                            i_frame_done,
    output logic                            o_render_ready,
    output logic                            o_hsync,
    output logic                            o_vsync,
    output logic                            o_de,
    output logic [pix_pkg::CHAN_WIDTH-1:0]  o_red,
    output logic [pix_pkg::CHAN_WIDTH-1:0]  o_green,
    output logic [pix_pkg::CHAN_WIDTH-1:0]  o_blue
);

    logic [disp_pkg::COORD_WIDTH-1:0] x;
    logic [disp_pkg::COORD_WIDTH-1:0] y;
    logic                             hsync;
    logic                             vsync;
    logic                             de;
    logic                             frame;

    logic                             pixel_accept;
    logic [disp_pkg::ADDR_WIDTH-1:0]  depth_raddr;
    logic [pix_pkg::DEPTH_WIDTH-1:0]  depth_rdata;
    logic                             wr_req;
    logic [disp_pkg::ADDR_WIDTH-1:0]  wr_addr;
    logic [pix_pkg::COLOR_WIDTH-1:0]  wr_color;
    logic [pix_pkg::DEPTH_WIDTH-1:0]  wr_depth;
    logic                             writer_busy;

    logic                             clear_req;
    logic [disp_pkg::ADDR_WIDTH-1:0]  clear_addr;
    logic                             clear_active;

    logic                             we;
    logic [disp_pkg::ADDR_WIDTH-1:0]  waddr;
    logic [pix_pkg::COLOR_WIDTH-1:0]  wcolor;
    logic [pix_pkg::DEPTH_WIDTH-1:0]  wdepth;
    logic [disp_pkg::ADDR_WIDTH-1:0]  scan_raddr;
    logic [pix_pkg::COLOR_WIDTH-1:0]  scan_rdata;

    // Pixels outside the ready window are dropped
    assign pixel_accept = i_pixel_valid && o_render_ready;

    video_timing u_timing (
        .clk     (clk),
        .rstn    (rstn),
        .o_x     (x),
        .o_y     (y),
        .o_hsync (hsync),
        .o_vsync (vsync),
        .o_de    (de),
        .o_frame (frame)
    );

    depth_writer u_writer (
        .clk           (clk),
        .rstn          (rstn),
        .i_pixel_valid (pixel_accept),
        .i_pixel_addr  (i_pixel_addr),
        .i_pixel_color (i_pixel_color),
        .i_pixel_depth (i_pixel_depth),
        .i_depth_rdata (depth_rdata),
        .o_depth_raddr (depth_raddr),
        .o_wr_req      (wr_req),
        .o_wr_addr     (wr_addr),
        .o_wr_color    (wr_color),
        .o_wr_depth    (wr_depth),
        .o_busy        (writer_busy)
    );

    buffer_clear u_clear (
        .clk           (clk),
        .rstn          (rstn),
        .i_start       (i_frame_clear),
        .i_writer_busy (writer_busy),
        .o_req         (clear_req),
        .o_addr        (clear_addr),
        .o_active      (clear_active)
    );

    buffer_arbiter u_arbiter (
        .clk            (clk),
        .rstn           (rstn),
        .i_clear_req    (clear_req),
        .i_clear_addr   (clear_addr),
        .i_writer_req   (wr_req),
        .i_writer_addr  (wr_addr),
        .i_writer_color (wr_color),
        .i_writer_depth (wr_depth),
        .o_we           (we),
        .o_addr         (waddr),
        .o_color        (wcolor),
        .o_depth        (wdepth)
    );

    frame_store u_store (
        .clk            (clk),
        .rstn           (rstn),
        .i_we           (we),
        .i_waddr        (waddr),
        .i_wcolor       (wcolor),
        .i_wdepth       (wdepth),
        .i_depth_raddr  (depth_raddr),
        .i_scan_raddr   (scan_raddr),
        .i_frame        (frame),
        .i_frame_done   (i_frame_done),
        .i_clear_active (clear_active),
        .o_depth_rdata  (depth_rdata),
        .o_scan_rdata   (scan_rdata),
        .o_render_ready (o_render_ready)
    );

    scanout u_scanout (
        .clk     (clk),
        .rstn    (rstn),
        .i_x     (x),
        .i_y     (y),
        .i_hsync (hsync),
        .i_vsync (vsync),
        .i_de    (de),
        .i_rdata (scan_rdata),
        .o_raddr (scan_raddr),
        .o_hsync (o_hsync),
        .o_vsync (o_vsync),
        .o_de    (o_de),
        .o_red   (o_red),
        .o_green (o_green),
        .o_blue  (o_blue)
    );

endmodule

// ==== source/scanout.sv ====
`timescale 1ns/1ns

module scanout (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic [disp_pkg::COORD_WIDTH-1:0] i_x,
    input  logic [disp_pkg::COORD_WIDTH-1:0] i_y,
    input  logic                             i_hsync,
    input  logic                             i_vsync,
    input  logic                             i_de,
    input  logic [pix_pkg::COLOR_WIDTH-1:0]  i_rdata,
    output logic [disp_pkg::ADDR_WIDTH-1:0]  o_raddr,
    output logic                             o_hsync,
    output logic                             o_vsync,
    output logic                             o_de,
    output logic [pix_pkg::CHAN_WIDTH-1:0]   o_red,
    output logic [pix_pkg::CHAN_WIDTH-1:0]   o_green,
    output logic [pix_pkg::CHAN_WIDTH-1:0]   o_blue
);

    logic hsync_d;
    logic vsync_d;
    logic de_d;

    // Parked at 0 outside the active area to stay in range
    always_comb begin
        o_raddr = '0;
        if (i_de) begin
            o_raddr = disp_pkg::ADDR_WIDTH'((i_y / disp_pkg::SCALE) * disp_pkg::FB_WIDTH
                                            + i_x / disp_pkg::SCALE);
        end
    end

    // First stage waits on the memory read, second looks up the palette
    always_ff @(posedge clk) begin
        if (!rstn) begin
            hsync_d <= ~disp_pkg::SYNC_ACTIVE;
            vsync_d <= ~disp_pkg::SYNC_ACTIVE;
            de_d    <= 1'b0;
            o_hsync <= ~disp_pkg::SYNC_ACTIVE;
            o_vsync <= ~disp_pkg::SYNC_ACTIVE;
            o_de    <= 1'b0;
            {o_red, o_green, o_blue} <= '0;
        end else begin
            hsync_d <= i_hsync;
            vsync_d <= i_vsync;
            de_d    <= i_de;
            o_hsync <= hsync_d;
            o_vsync <= vsync_d;
            o_de    <= de_d;
            if (de_d) begin
                {o_red, o_green, o_blue} <= pix_pkg::PALETTE[i_rdata];
            end else begin
                {o_red, o_green, o_blue} <= '0;
            end
        end
    end

endmodule

// ==== source/frame_store.sv ====
`timescale 1ns/1ns

module frame_store (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            i_we,
    input  logic [disp_pkg::ADDR_WIDTH-1:0] i_waddr,
    input  logic [pix_pkg::COLOR_WIDTH-1:0] i_wcolor,
    input  logic [pix_pkg::DEPTH_WIDTH-1:0] i_wdepth,
    input  logic [disp_pkg::ADDR_WIDTH-1:0] i_depth_raddr,
    input  logic [disp_pkg::ADDR_WIDTH-1:0] i_scan_raddr,
    input  logic                            i_frame,
    input  logic                            i_frame_done,
    input  logic                            i_clear_active,
    output logic [pix_pkg::DEPTH_WIDTH-1:0] o_depth_rdata,
    output logic [pix_pkg::COLOR_WIDTH-1:0] o_scan_rdata,
    output logic                            o_render_ready
);

    logic [pix_pkg::COLOR_WIDTH-1:0] fb0 [disp_pkg::FB_DEPTH];
    logic [pix_pkg::COLOR_WIDTH-1:0] fb1 [disp_pkg::FB_DEPTH];
    logic [pix_pkg::DEPTH_WIDTH-1:0] db  [disp_pkg::FB_DEPTH];

    // Index of the back buffer, the other one is scanned out
    logic sel;
    logic swap_pending;

    always_ff @(posedge clk) begin
        if (i_we && !sel) begin
            fb0[i_waddr] <= i_wcolor;
        end
    end

    always_ff @(posedge clk) begin
        if (i_we && sel) begin
            fb1[i_waddr] <= i_wcolor;
        end
    end

    // Read returns the old word on a same-address write
    always_ff @(posedge clk) begin
        if (i_we) begin
            db[i_waddr] <= i_wdepth;
        end
        o_depth_rdata <= db[i_depth_raddr];
    end

    always_ff @(posedge clk) begin
        if (sel) begin
            o_scan_rdata <= fb0[i_scan_raddr];
        end else begin
            o_scan_rdata <= fb1[i_scan_raddr];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            sel          <= 1'b0;
            swap_pending <= 1'b0;
        end else if (swap_pending && i_frame) begin
            sel          <= ~sel;
            swap_pending <= 1'b0;
        end else if (i_frame_done) begin
            swap_pending <= 1'b1;
        end
    end

    assign o_render_ready = !i_clear_active && !swap_pending;

endmodule

// ==== source/buffer_arbiter.sv ====
`timescale 1ns/1ns

module buffer_arbiter (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            i_clear_req,
    input  logic [disp_pkg::ADDR_WIDTH-1:0] i_clear_addr,
    input  logic                            i_writer_req,
    input  logic [disp_pkg::ADDR_WIDTH-1:0] i_writer_addr,
    input  logic [pix_pkg::COLOR_WIDTH-1:0] i_writer_color,
    input  logic [pix_pkg::DEPTH_WIDTH-1:0] i_writer_depth,
    output logic                            o_we,
    output logic [disp_pkg::ADDR_WIDTH-1:0] o_addr,
    output logic [pix_pkg::COLOR_WIDTH-1:0] o_color,
    output logic [pix_pkg::DEPTH_WIDTH-1:0] o_depth
);

    pix_pkg::grant_t grant_q;
    pix_pkg::grant_t grant;

    // Writer holds on while it still requests, else clear first
    always_comb begin
        if (grant_q == pix_pkg::GRANT_WRITER && i_writer_req) begin
            grant = pix_pkg::GRANT_WRITER;
        end else if (i_clear_req) begin
            grant = pix_pkg::GRANT_CLEAR;
        end else if (i_writer_req) begin
            grant = pix_pkg::GRANT_WRITER;
        end else begin
            grant = pix_pkg::GRANT_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            grant_q <= pix_pkg::GRANT_NONE;
        end else begin
            grant_q <= grant;
        end
    end

    always_comb begin
        o_we    = (grant != pix_pkg::GRANT_NONE);
        o_addr  = i_writer_addr;
        o_color = i_writer_color;
        o_depth = i_writer_depth;
        if (grant == pix_pkg::GRANT_CLEAR) begin
            o_addr  = i_clear_addr;
            o_color = pix_pkg::FB_CLEAR_VALUE;
            o_depth = pix_pkg::DB_CLEAR_VALUE;
        end
    end

endmodule

// ==== source/buffer_clear.sv ====
`timescale 1ns/1ns

module buffer_clear (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            i_start,
    input  logic                            i_writer_busy,
    output logic                            o_req,
    output logic [disp_pkg::ADDR_WIDTH-1:0] o_addr,
    output logic                            o_active
);

    pix_pkg::clear_state_t           state;
    logic [disp_pkg::ADDR_WIDTH-1:0] addr;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= pix_pkg::IDLE;
            addr  <= '0;
        end else begin
            case (state)
                pix_pkg::IDLE: begin
                    if (i_start) begin
                        state <= pix_pkg::DRAIN;
                        addr  <= '0;
                    end
                end
                // Let pixels in flight finish first
                pix_pkg::DRAIN: begin
                    if (!i_writer_busy) begin
                        state <= pix_pkg::SWEEP;
                    end
                end
                pix_pkg::SWEEP: begin
                    if (addr == disp_pkg::FB_DEPTH - 1) begin
                        state <= pix_pkg::IDLE;
                    end
                    addr <= addr + 1'b1;
                end
                default: state <= pix_pkg::IDLE;
            endcase
        end
    end

    assign o_req    = (state == pix_pkg::SWEEP);
    assign o_addr   = addr;
    assign o_active = (state != pix_pkg::IDLE);

endmodule

// ==== source/depth_writer.sv ====
`timescale 1ns/1ns

module depth_writer (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            i_pixel_valid,
    input  logic [disp_pkg::ADDR_WIDTH-1:0] i_pixel_addr,
    input  logic [pix_pkg::COLOR_WIDTH-1:0] i_pixel_color,
    input  logic [pix_pkg::DEPTH_WIDTH-1:0] i_pixel_depth,
    input  logic [pix_pkg::DEPTH_WIDTH-1:0] i_depth_rdata,
    output logic [disp_pkg::ADDR_WIDTH-1:0] o_depth_raddr,
    output logic                            o_wr_req,
    output logic [disp_pkg::ADDR_WIDTH-1:0] o_wr_addr,
    output logic [pix_pkg::COLOR_WIDTH-1:0] o_wr_color,
    output logic [pix_pkg::DEPTH_WIDTH-1:0] o_wr_depth,
    output logic                            o_busy
);

    // Stage one holds the pixel while its depth is read
    logic                            s1_valid;
    logic [disp_pkg::ADDR_WIDTH-1:0] s1_addr;
    logic [pix_pkg::COLOR_WIDTH-1:0] s1_color;
    logic [pix_pkg::DEPTH_WIDTH-1:0] s1_depth;

    // Stage two keeps the write that just landed
    logic                            s2_valid;
    logic [disp_pkg::ADDR_WIDTH-1:0] s2_addr;
    logic [pix_pkg::DEPTH_WIDTH-1:0] s2_depth;

    logic [pix_pkg::DEPTH_WIDTH-1:0] ref_depth;

    // Read issued in the accept cycle
    assign o_depth_raddr = i_pixel_addr;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= i_pixel_valid;
            s2_valid <= o_wr_req;
        end
    end

    always_ff @(posedge clk) begin
        if (i_pixel_valid) begin
            s1_addr  <= i_pixel_addr;
            s1_color <= i_pixel_color;
            s1_depth <= i_pixel_depth;
        end
        if (o_wr_req) begin
            s2_addr  <= s1_addr;
            s2_depth <= s1_depth;
        end
    end

    // Memory read missed the write at the same edge
    always_comb begin
        ref_depth = i_depth_rdata;
        if (s2_valid && s2_addr == s1_addr) begin
            ref_depth = s2_depth;
        end
    end

    // Strictly closer wins, so equal depth keeps the earlier pixel
    assign o_wr_req   = s1_valid && (s1_depth < ref_depth);
    assign o_wr_addr  = s1_addr;
    assign o_wr_color = s1_color;
    assign o_wr_depth = s1_depth;
    assign o_busy     = s1_valid || s2_valid;

endmodule

// ==== source/video_timing.sv ====
`timescale 1ns/1ns

module video_timing (
    input  logic                             clk,
    input  logic                             rstn,
    output logic [disp_pkg::COORD_WIDTH-1:0] o_x,
    output logic [disp_pkg::COORD_WIDTH-1:0] o_y,
    output logic                             o_hsync,
    output logic                             o_vsync,
    output logic                             o_de,
    output logic                             o_frame
);

    logic line_end;
    logic frame_end;

    assign line_end  = (o_x == disp_pkg::H_TOTAL - 1);
    assign frame_end = (o_y == disp_pkg::V_TOTAL - 1);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_x <= '0;
            o_y <= '0;
        end else if (line_end) begin
            o_x <= '0;
            if (frame_end) begin
                o_y <= '0;
            end else begin
                o_y <= o_y + 1'b1;
            end
        end else begin
            o_x <= o_x + 1'b1;
        end
    end

    always_comb begin
        o_hsync = ~disp_pkg::SYNC_ACTIVE;
        o_vsync = ~disp_pkg::SYNC_ACTIVE;
        if (o_x >= disp_pkg::H_SYNC_START && o_x < disp_pkg::H_SYNC_END) begin
            o_hsync = disp_pkg::SYNC_ACTIVE;
        end
        if (o_y >= disp_pkg::V_SYNC_START && o_y < disp_pkg::V_SYNC_END) begin
            o_vsync = disp_pkg::SYNC_ACTIVE;
        end
    end

    assign o_de    = (o_x < disp_pkg::H_ACTIVE) && (o_y < disp_pkg::V_ACTIVE);
    // Last position of the frame
    assign o_frame = line_end && frame_end;

endmodule

// ==== source/pix_pkg.sv ====
package pix_pkg;

    localparam int COLOR_WIDTH = 4;
    localparam int DEPTH_WIDTH = 8;
    localparam int CHAN_WIDTH  = 4;
    localparam int RGB_WIDTH   = 3 * CHAN_WIDTH;

    localparam logic [COLOR_WIDTH-1:0] FB_CLEAR_VALUE = '0;
    localparam logic [DEPTH_WIDTH-1:0] DB_CLEAR_VALUE = '1;

    // Red, green, blue nibbles per index
    localparam logic [RGB_WIDTH-1:0] PALETTE [1 << COLOR_WIDTH] = '{
        12'h000, 12'h00a, 12'h0a0, 12'h0aa,
        12'ha00, 12'ha0a, 12'ha50, 12'haaa,
        12'h555, 12'h55f, 12'h5f5, 12'h5ff,
        12'hf55, 12'hf5f, 12'hff5, 12'hfff
    };

    typedef enum logic [1:0] {
        IDLE,
        DRAIN,
        SWEEP
    } clear_state_t;

    typedef enum logic [1:0] {
        GRANT_NONE,
        GRANT_WRITER,
        GRANT_CLEAR
    } grant_t;

endpackage

// ==== source/disp_pkg.sv ====
package disp_pkg;

    // Framebuffer geometry
    localparam int FB_WIDTH   = 16;
    localparam int FB_HEIGHT  = 12;
    localparam int SCALE      = 2;
    localparam int FB_DEPTH   = FB_WIDTH * FB_HEIGHT;
    localparam int ADDR_WIDTH = 8;

    // Horizontal timing in clocks
    localparam int H_ACTIVE     = 32;
    localparam int H_SYNC_START = 34;
    localparam int H_SYNC_END   = 37;
    localparam int H_TOTAL      = 40;

    // Vertical timing in lines
    localparam int V_ACTIVE     = 24;
    localparam int V_SYNC_START = 25;
    localparam int V_SYNC_END   = 26;
    localparam int V_TOTAL      = 28;

    localparam int COORD_WIDTH = 6;

    // Counter position to video output delay
    localparam int SCAN_LATENCY = 2;

    // Both syncs are active low
    localparam logic SYNC_ACTIVE = 1'b0;

endpackage
